/* verilog/engine_csr_index_pkg.sv */
package engine_csr_index_pkg;

    // ------------------------------------------------
    // Widths
    // ------------------------------------------------
    parameter int ADDRESS_WIDTH = 32;
    parameter int DATA_WIDTH    = 32;
    parameter int INDEX_WIDTH   = 32;

    // Tag and vertex count share this width, so a run holds at most 255 indices
    parameter int TAG_WIDTH = 8;

    // Size of one index word in memory
    parameter int INDEX_BYTES = 4;

    // ------------------------------------------------
    // Packets
    // ------------------------------------------------
    typedef struct packed {
        logic [ADDRESS_WIDTH-1:0] address;
        logic [TAG_WIDTH-1:0]     tag;
    } memory_request_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [TAG_WIDTH-1:0]  tag;
    } memory_response_t;

    // Absolute index plus the word read for it
    typedef struct packed {
        logic [INDEX_WIDTH-1:0] index;
        logic [DATA_WIDTH-1:0]  data;
    } engine_request_t;

endpackage : engine_csr_index_pkg

/* verilog/csr_config_if.sv */
`timescale 1ns/1ns

interface csr_config_if;
    import engine_csr_index_pkg::*;

    logic                     active;
    logic                     start;
    logic [ADDRESS_WIDTH-1:0] base_address;
    logic [INDEX_WIDTH-1:0]   start_index;
    logic [TAG_WIDTH-1:0]     count;
    logic                     finished;

    // Descriptor holder
    modport source (
        output active, start, base_address, start_index, count,
        input  finished
    );

    modport generator (
        input active, start, base_address, start_index, count
    );

    // Response side only needs the range
    modport collector (
        input  start, start_index, count,
        output finished
    );

endinterface : csr_config_if

/* verilog/csr_index_fifo.sv */
`timescale 1ns/1ns

module csr_index_fifo #(
    parameter type payload_t   = logic [31:0],
    parameter int  FIFO_DEPTH  = 16,
    parameter int  PROG_THRESH = 8
) (
    input  logic     ap_clk,
    input  logic     areset_csr_engine,
    input  logic     push,
    input  payload_t push_payload,
    input  logic     pop,
    output payload_t pop_payload,
    output logic     valid,
    output logic     full,
    output logic     prog_full
);

    localparam int PTR_WIDTH   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    payload_t               buffer [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0]   write_ptr;
    logic [PTR_WIDTH-1:0]   read_ptr;
    logic [COUNT_WIDTH-1:0] occupancy;
    logic                   write_en;
    logic                   read_en;

    assign write_en = push & ~full;
    assign read_en  = pop & valid;

    // ------------------------------------------------
    // Storage
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (write_en) begin
            buffer[write_ptr] <= push_payload;
        end
    end

    // Head item is visible before the pop
    assign pop_payload = buffer[read_ptr];

    // ------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            write_ptr <= '0;
            read_ptr  <= '0;
            occupancy <= '0;
        end
        else begin
            if (write_en) begin
                write_ptr <= (write_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : write_ptr + 1'b1;
            end
            if (read_en) begin
                read_ptr <= (read_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : read_ptr + 1'b1;
            end
            case ({write_en, read_en})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    assign valid     = (occupancy != '0);
    assign full      = (occupancy == COUNT_WIDTH'(FIFO_DEPTH));
    assign prog_full = (occupancy >= COUNT_WIDTH'(PROG_THRESH));

    // Producer and consumer must honour the flags
    push_when_full : assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine) push |-> !full
    ) else $error("FIFO pushed while full");

    pop_when_empty : assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine) pop |-> valid
    ) else $error("FIFO popped while empty");

endmodule : csr_index_fifo

/* verilog/csr_index_configure.sv */
`timescale 1ns/1ns

module csr_index_configure (
    input  logic                                         ap_clk,
    input  logic                                         areset_csr_engine,
    input  logic                                         descriptor_valid,
    input  logic [engine_csr_index_pkg::ADDRESS_WIDTH-1:0] descriptor_base_address,
    input  logic [engine_csr_index_pkg::INDEX_WIDTH-1:0]   descriptor_start_index,
    input  logic [engine_csr_index_pkg::TAG_WIDTH-1:0]     descriptor_count,
    output logic                                         done,
    csr_config_if.source                                 csr_config
);

    logic accept;
    logic nonzero;

    // Descriptors only count while idle
    assign accept  = descriptor_valid & done;
    assign nonzero = |descriptor_count;

    // Descriptor fields, held for the whole run
    always_ff @(posedge ap_clk) begin
        if (accept) begin
            csr_config.base_address <= descriptor_base_address;
            csr_config.start_index  <= descriptor_start_index;
            csr_config.count        <= descriptor_count;
        end
    end

    // ------------------------------------------------
    // Run control
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            csr_config.active <= 1'b0;
            csr_config.start  <= 1'b0;
            done              <= 1'b1;
        end
        else begin
            csr_config.start <= accept & nonzero;
            if (accept) begin
                // Empty range never goes active
                csr_config.active <= nonzero;
                done              <= 1'b0;
            end
            else if (csr_config.active) begin
                if (csr_config.finished) begin
                    csr_config.active <= 1'b0;
                    done              <= 1'b1;
                end
            end
            else begin
                done <= 1'b1;
            end
        end
    end

    // Completion pulse only belongs to a live run
    finished_while_idle : assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine) csr_config.finished |-> csr_config.active
    ) else $error("Response stage finished while no descriptor was active");

endmodule : csr_index_configure

/* verilog/csr_index_generator.sv */
`timescale 1ns/1ns

module csr_index_generator (
    input  logic                                  ap_clk,
    input  logic                                  areset_csr_engine,
    input  logic                                  request_prog_full,
    output logic                                  request_push,
    output engine_csr_index_pkg::memory_request_t request_payload,
    csr_config_if.generator                       csr_config
);
    import engine_csr_index_pkg::*;

    logic [TAG_WIDTH-1:0]   offset;
    logic [TAG_WIDTH-1:0]   offset_next;
    logic                   walking;
    logic [INDEX_WIDTH-1:0] index;

    // ------------------------------------------------
    // Offset walk
    // ------------------------------------------------
    assign offset_next = offset + 1'b1;

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            offset  <= '0;
            walking <= 1'b0;
        end
        else begin
            if (csr_config.start) begin
                offset  <= '0;
                walking <= 1'b1;
            end
            else if (request_push) begin
                offset <= offset_next;
                // Last index of the range goes out this cycle
                if (offset_next == csr_config.count) begin
                    walking <= 1'b0;
                end
            end
        end
    end

    // Hold off while the request FIFO is near full
    assign request_push = walking & ~request_prog_full;

    // ------------------------------------------------
    // Request payload
    // ------------------------------------------------
    assign index = csr_config.start_index + INDEX_WIDTH'(offset);

    always_comb begin
        request_payload.address = csr_config.base_address
                                + ADDRESS_WIDTH'(index) * ADDRESS_WIDTH'(INDEX_BYTES);
        // Tag is the offset from the first index
        request_payload.tag     = offset;
    end

    push_while_inactive : assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine) request_push |-> csr_config.active
    ) else $error("Memory request issued with no active descriptor");

endmodule : csr_index_generator

/* verilog/csr_index_response.sv */
`timescale 1ns/1ns

module csr_index_response (
    input  logic                                   ap_clk,
    input  logic                                   areset_csr_engine,
    input  logic                                   response_valid,
    input  engine_csr_index_pkg::memory_response_t response_payload,
    input  logic                                   engine_prog_full,
    input  logic                                   engine_pop,
    output logic                                   response_pop,
    output logic                                   engine_push,
    output engine_csr_index_pkg::engine_request_t  engine_payload,
    csr_config_if.collector                        csr_config
);
    import engine_csr_index_pkg::*;

    logic [TAG_WIDTH-1:0] taken;
    logic                 armed;

    // ------------------------------------------------
    // Response to engine request
    // ------------------------------------------------
    // One response per cycle, only when the engine FIFO has room
    assign response_pop = response_valid & ~engine_prog_full;
    assign engine_push  = response_pop;

    always_comb begin
        engine_payload.index = csr_config.start_index + INDEX_WIDTH'(response_payload.tag);
        engine_payload.data  = response_payload.data;
    end

    // ------------------------------------------------
    // Completion count
    // ------------------------------------------------
    // Counted at the engine output, so done waits for the last transfer
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            taken               <= '0;
            armed               <= 1'b0;
            csr_config.finished <= 1'b0;
        end
        else begin
            csr_config.finished <= 1'b0;
            if (csr_config.start) begin
                taken <= '0;
                armed <= 1'b1;
            end
            else begin
                if (engine_pop) begin
                    taken <= taken + 1'b1;
                end
                if (armed && taken == csr_config.count) begin
                    csr_config.finished <= 1'b1;
                    armed               <= 1'b0;
                end
            end
        end
    end

    // Memory must only return tags that were issued
    tag_in_range : assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        response_pop |-> (response_payload.tag < csr_config.count)
    ) else $error("Memory response tag outside the descriptor range");

endmodule : csr_index_response

/* verilog/engine_csr_index.sv */
`timescale 1ns/1ns

module engine_csr_index #(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic                                         ap_clk,
    input  logic                                         areset_csr_engine,
    input  logic                                         descriptor_valid,
    input  logic [engine_csr_index_pkg::ADDRESS_WIDTH-1:0] descriptor_base_address,
    input  logic [engine_csr_index_pkg::INDEX_WIDTH-1:0]   descriptor_start_index,
    input  logic [engine_csr_index_pkg::TAG_WIDTH-1:0]     descriptor_count,
    output logic                                         done,
    input  logic                                         memory_request_ready,
    output logic                                         memory_request_valid,
    output logic [engine_csr_index_pkg::ADDRESS_WIDTH-1:0] memory_request_address,
    output logic [engine_csr_index_pkg::TAG_WIDTH-1:0]     memory_request_tag,
    input  logic                                         memory_response_valid,
    input  logic [engine_csr_index_pkg::DATA_WIDTH-1:0]    memory_response_data,
    input  logic [engine_csr_index_pkg::TAG_WIDTH-1:0]     memory_response_tag,
    output logic                                         memory_response_ready,
    input  logic                                         engine_request_ready,
    output logic                                         engine_request_valid,
    output logic [engine_csr_index_pkg::INDEX_WIDTH-1:0]   engine_request_index,
    output logic [engine_csr_index_pkg::DATA_WIDTH-1:0]    engine_request_data
);
    import engine_csr_index_pkg::*;

    // ------------------------------------------------
    // Wires
    // ------------------------------------------------
    memory_request_t  request_payload;
    memory_request_t  request_head;
    logic             request_push;
    logic             request_pop;
    logic             request_prog_full;

    memory_response_t response_in;
    memory_response_t response_head;
    logic             response_valid;
    logic             response_pop;
    logic             response_prog_full;

    engine_request_t  engine_payload;
    engine_request_t  engine_head;
    logic             engine_push;
    logic             engine_pop;
    logic             engine_prog_full;

    csr_config_if csr_config ();

    // ------------------------------------------------
    // Control stages
    // ------------------------------------------------
    csr_index_configure i_csr_index_configure (
        .ap_clk                 (ap_clk),
        .areset_csr_engine      (areset_csr_engine),
        .descriptor_valid       (descriptor_valid),
        .descriptor_base_address(descriptor_base_address),
        .descriptor_start_index (descriptor_start_index),
        .descriptor_count       (descriptor_count),
        .done                   (done),
        .csr_config             (csr_config)
    );

    csr_index_generator i_csr_index_generator (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .request_prog_full(request_prog_full),
        .request_push     (request_push),
        .request_payload  (request_payload),
        .csr_config       (csr_config)
    );

    csr_index_response i_csr_index_response (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .response_valid   (response_valid),
        .response_payload (response_head),
        .engine_prog_full (engine_prog_full),
        .engine_pop       (engine_pop),
        .response_pop     (response_pop),
        .engine_push      (engine_push),
        .engine_payload   (engine_payload),
        .csr_config       (csr_config)
    );

    // ------------------------------------------------
    // Memory request out
    // ------------------------------------------------
    assign request_pop            = memory_request_valid & memory_request_ready;
    assign memory_request_address = request_head.address;
    assign memory_request_tag     = request_head.tag;

    csr_index_fifo #(
        .payload_t  (memory_request_t),
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) i_request_fifo (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .push             (request_push),
        .push_payload     (request_payload),
        .pop              (request_pop),
        .pop_payload      (request_head),
        .valid            (memory_request_valid),
        .full             (),
        .prog_full        (request_prog_full)
    );

    // ------------------------------------------------
    // Memory response in
    // ------------------------------------------------
    assign response_in.data      = memory_response_data;
    assign response_in.tag       = memory_response_tag;
    assign memory_response_ready = ~response_prog_full;

    csr_index_fifo #(
        .payload_t  (memory_response_t),
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) i_response_fifo (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .push             (memory_response_valid),
        .push_payload     (response_in),
        .pop              (response_pop),
        .pop_payload      (response_head),
        .valid            (response_valid),
        .full             (),
        .prog_full        (response_prog_full)
    );

    // ------------------------------------------------
    // Engine request out
    // ------------------------------------------------
    assign engine_pop           = engine_request_valid & engine_request_ready;
    assign engine_request_index = engine_head.index;
    assign engine_request_data  = engine_head.data;

    csr_index_fifo #(
        .payload_t  (engine_request_t),
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) i_engine_fifo (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .push             (engine_push),
        .push_payload     (engine_payload),
        .pop              (engine_pop),
        .pop_payload      (engine_head),
        .valid            (engine_request_valid),
        .full             (),
        .prog_full        (engine_prog_full)
    );

endmodule : engine_csr_index

/* testbench/tb_engine_csr_index.sv */
`timescale 1ns/1ns

module tb_engine_csr_index;

    localparam int          TIMEOUT_CYCLES = 4000;
    localparam logic [31:0] RANDOM_SEED    = 32'h5df4c369;
    localparam logic [31:0] DATA_MASK      = 32'h5a5a0000;

    logic        ap_clk;
    logic        areset_csr_engine;
    logic        descriptor_valid;
    logic [31:0] descriptor_base_address;
    logic [31:0] descriptor_start_index;
    logic [7:0]  descriptor_count;
    logic        done;
    logic        memory_request_ready;
    logic        memory_request_valid;
    logic [31:0] memory_request_address;
    logic [7:0]  memory_request_tag;
    logic        memory_response_valid;
    logic [31:0] memory_response_data;
    logic [7:0]  memory_response_tag;
    logic        memory_response_ready;
    logic        engine_request_ready;
    logic        engine_request_valid;
    logic [31:0] engine_request_index;
    logic [31:0] engine_request_data;

    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;
    int last_engine_cycle = 0;

    // Ready policies set by the tests
    bit random_memory = 0;
    bit random_engine = 0;
    bit hold_engine   = 0;
    bit saw_response_stall = 0;

    // Transfers seen at the DUT boundary
    logic [31:0] issued_address [$];
    logic [7:0]  issued_tag [$];
    logic [31:0] received_index [$];
    logic [31:0] received_data [$];

    // Outstanding reads inside the memory model
    logic [31:0] pending_address [$];
    logic [7:0]  pending_tag [$];
    int          pending_delay [$];

    engine_csr_index i_engine_csr_index (.*);

    always #20 ap_clk = ~ap_clk;

    // Run limit
    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    // --------------------------------------------------
    // Memory model and output monitors
    // --------------------------------------------------
    always @(negedge ap_clk) begin : memory_model
        int ready_slots [$];
        int pick;
        int slot;
        ready_slots.delete();
        if (areset_csr_engine) begin
            memory_request_ready  = 1'b0;
            engine_request_ready  = 1'b0;
            memory_response_valid = 1'b0;
        end
        else begin
            memory_request_ready = random_memory ? 1'($urandom % 2) : 1'b1;
            if (hold_engine) begin
                engine_request_ready = 1'b0;
            end
            else begin
                engine_request_ready = random_engine ? 1'($urandom % 2) : 1'b1;
            end

            // Return one due read picked at random while the DUT has room
            memory_response_valid = 1'b0;
            if (!memory_response_ready) begin
                saw_response_stall = 1'b1;
            end
            else begin
                foreach (pending_delay[i]) begin
                    if (pending_delay[i] == 0) begin
                        ready_slots.push_back(i);
                    end
                end
                if (ready_slots.size() > 0) begin
                    pick = $urandom_range(ready_slots.size() - 1, 0);
                    slot = ready_slots[pick];
                    memory_response_valid = 1'b1;
                    memory_response_data  = pending_address[slot] ^ DATA_MASK;
                    memory_response_tag   = pending_tag[slot];
                    pending_address.delete(slot);
                    pending_tag.delete(slot);
                    pending_delay.delete(slot);
                end
            end
            foreach (pending_delay[i]) begin
                if (pending_delay[i] > 0) begin
                    pending_delay[i]--;
                end
            end

            // Transfers complete at the coming rising edge
            if (memory_request_valid && memory_request_ready) begin
                pending_address.push_back(memory_request_address);
                pending_tag.push_back(memory_request_tag);
                pending_delay.push_back($urandom_range(12, 1));
                issued_address.push_back(memory_request_address);
                issued_tag.push_back(memory_request_tag);
            end
            if (engine_request_valid && engine_request_ready) begin
                received_index.push_back(engine_request_index);
                received_data.push_back(engine_request_data);
                last_engine_cycle = cycle_count + 1;
            end
        end
    end

    // --------------------------------------------------
    // Check helpers
    // --------------------------------------------------
    task automatic compare_value(string name, logic [31:0] actual, logic [31:0] expected);
        check_count++;
        assert (actual === expected) else begin
            $display("Fail %s: got %h, expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic expect_true(bit condition, string message);
        check_count++;
        assert (condition) else begin
            $display("Error: %s", message);
            error_count++;
        end
    endtask

    task automatic clear_logs();
        issued_address.delete();
        issued_tag.delete();
        received_index.delete();
        received_data.delete();
    endtask

    // Each index of the range read once at its own word
    task automatic check_requests(logic [31:0] base, logic [31:0] start, logic [7:0] count);
        bit seen [256];
        compare_value("memory request count", issued_tag.size(), 32'(count));
        foreach (issued_tag[i]) begin
            expect_true(issued_tag[i] < count, "memory request tag outside the descriptor range");
            if (issued_tag[i] < count) begin
                expect_true(!seen[issued_tag[i]], "memory request tag issued twice");
                seen[issued_tag[i]] = 1'b1;
                compare_value("memory_request_address", issued_address[i],
                              base + (start + 32'(issued_tag[i])) * 32'd4);
            end
        end
    endtask

    task automatic check_responses(logic [31:0] base, logic [31:0] start, logic [7:0] count);
        bit          seen [256];
        logic [31:0] offset;
        compare_value("engine request count", received_index.size(), 32'(count));
        foreach (received_index[i]) begin
            offset = received_index[i] - start;
            expect_true(offset < 32'(count), "engine request index outside the descriptor range");
            if (offset < 32'(count)) begin
                expect_true(!seen[offset], "engine request index delivered twice");
                seen[offset] = 1'b1;
                compare_value("engine_request_data", received_data[i],
                              (base + received_index[i] * 32'd4) ^ DATA_MASK);
            end
        end
    endtask

    // --------------------------------------------------
    // Descriptor sequencing
    // --------------------------------------------------
    // idle reports done as the DUT sees it at the sampling edge
    task automatic send_descriptor(logic [31:0] base, logic [31:0] start, logic [7:0] count,
                                   output bit idle);
        @(negedge ap_clk);
        descriptor_valid        = 1'b1;
        descriptor_base_address = base;
        descriptor_start_index  = start;
        descriptor_count        = count;
        idle                    = done;
        @(negedge ap_clk);
        descriptor_valid = 1'b0;
    endtask

    task automatic start_run(logic [31:0] base, logic [31:0] start, logic [7:0] count);
        int waited;
        bit was_idle;
        waited = 0;
        clear_logs();
        send_descriptor(base, start, count, was_idle);
        expect_true(was_idle, "descriptor was presented while the engine was busy");
        while (done && waited < 2) begin
            @(negedge ap_clk);
            waited++;
        end
        expect_true(!done, "done did not fall within 2 cycles of an accepted descriptor");
    endtask

    task automatic finish_run(logic [31:0] base, logic [31:0] start, logic [7:0] count);
        while (!done) begin
            @(negedge ap_clk);
        end
        expect_true(cycle_count - last_engine_cycle <= 3,
                    "done rose later than 3 cycles after the last engine request");
        check_requests(base, start, count);
        check_responses(base, start, count);
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_reset_state();
        compare_value("done", 32'(done), 32'd1);
        compare_value("memory_request_valid", 32'(memory_request_valid), 32'd0);
        compare_value("engine_request_valid", 32'(engine_request_valid), 32'd0);
    endtask

    task automatic test_single_range();
        start_run(32'h1000, 32'd7, 8'd5);
        finish_run(32'h1000, 32'd7, 8'd5);
    endtask

    task automatic test_out_of_order();
        bit in_order;
        in_order = 1'b1;
        start_run(32'h8000, 32'd100, 8'd12);
        finish_run(32'h8000, 32'd100, 8'd12);
        foreach (received_index[i]) begin
            if (received_index[i] != 32'd100 + 32'(i)) begin
                in_order = 1'b0;
            end
        end
        expect_true(!in_order, "engine requests never left issue order");
    endtask

    task automatic test_back_pressure();
        random_memory      <= 1'b1;
        hold_engine        <= 1'b1;
        saw_response_stall = 1'b0;
        start_run(32'h20000, 32'd300, 8'd40);
        repeat (100) @(negedge ap_clk);
        compare_value("engine requests while held", received_index.size(), 32'd0);
        hold_engine   <= 1'b0;
        random_engine <= 1'b1;
        finish_run(32'h20000, 32'd300, 8'd40);
        expect_true(saw_response_stall, "memory_response_ready never dropped under back-pressure");
        random_memory <= 1'b0;
        random_engine <= 1'b0;
    endtask

    task automatic test_zero_count();
        int low_cycles;
        bit was_idle;
        low_cycles = 1;
        clear_logs();
        send_descriptor(32'h2000, 32'd3, 8'd0, was_idle);
        expect_true(was_idle, "empty descriptor was presented while the engine was busy");
        while (!done && low_cycles <= 2) begin
            @(negedge ap_clk);
            low_cycles++;
        end
        expect_true(done, "done stayed low for more than 2 cycles on an empty descriptor");
        repeat (10) @(negedge ap_clk);
        compare_value("memory request count", issued_tag.size(), 32'd0);
        compare_value("engine request count", received_index.size(), 32'd0);
    endtask

    // Second descriptor lands while busy and must be dropped
    task automatic test_busy_descriptor();
        bit was_idle;
        start_run(32'h3000, 32'd20, 8'd6);
        send_descriptor(32'h4000, 32'd50, 8'd6, was_idle);
        expect_true(!was_idle, "second descriptor was presented while the engine was idle");
        finish_run(32'h3000, 32'd20, 8'd6);
        repeat (10) @(negedge ap_clk);
        compare_value("memory request count", issued_tag.size(), 32'd6);
        compare_value("done", 32'(done), 32'd1);
    endtask

    initial begin
        void'($urandom(RANDOM_SEED));
        ap_clk                  = 1'b0;
        areset_csr_engine       = 1'b1;
        descriptor_valid        = 1'b0;
        descriptor_base_address = '0;
        descriptor_start_index  = '0;
        descriptor_count        = '0;
        memory_request_ready    = 1'b0;
        memory_response_valid   = 1'b0;
        memory_response_data    = '0;
        memory_response_tag     = '0;
        engine_request_ready    = 1'b0;

        repeat (5) @(negedge ap_clk);
        areset_csr_engine = 1'b0;
        @(negedge ap_clk);

        test_reset_state();
        test_single_range();
        test_out_of_order();
        test_back_pressure();
        test_zero_count();
        test_busy_descriptor();
        repeat (5) @(negedge ap_clk);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end
        else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : tb_engine_csr_index

/* engine_csr_index.f */
verilog/engine_csr_index_pkg.sv
verilog/csr_config_if.sv
verilog/csr_index_fifo.sv
verilog/csr_index_configure.sv
verilog/csr_index_generator.sv
verilog/csr_index_response.sv
verilog/engine_csr_index.sv
testbench/tb_engine_csr_index.sv

/* Makefile */
SIM       = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_engine_csr_index
FILELIST  = engine_csr_index.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
